// File: hdl/loader_defines.svh
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// Serial line
`define UART_BAUD_DIV    16
`define LDR_IDLE_CYCLES  400

// Memory map
`define RAM_ADDR_BITS    8
`define RAM_BASE         32'h0000_0000
`define GPIO_BASE        32'h1F80_0000

// Board I/O widths
`define N_LEDS           16
`define N_SWITCHES       16

`endif

// File: hdl/loader_pkg.sv
package loader_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Master side, address phase and data phase together
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    // Slave side
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module uart_rx (
    input  logic       hclk,
    input  logic       rst_n,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);
    localparam int CNT_W = $clog2(`UART_BAUD_DIV);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_s;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    logic             half_tick;
    logic             full_tick;
    logic             shift_en;

    assign half_tick = baud_cnt == CNT_W'(`UART_BAUD_DIV / 2 - 1);
    assign full_tick = baud_cnt == CNT_W'(`UART_BAUD_DIV - 1);
    assign shift_en  = state == RX_DATA && full_tick;

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            baud_cnt   <= baud_cnt + CNT_W'(1);
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_s)
                        state <= RX_START;
                end
                RX_START: begin
                    if (half_tick) begin  // Middle of start bit
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s ? RX_IDLE : RX_DATA;  // Glitch rejected
                    end
                end
                RX_DATA: begin
                    if (full_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (full_tick) begin
                        byte_valid <= rx_s;  // Framing error drops the byte
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge hclk) begin
        if (shift_en)
            byte_data <= {rx_s, byte_data[7:1]};  // LSB first
    end
endmodule

// File: hdl/uart_loader.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module uart_loader (
    input  logic                 hclk,
    input  logic                 rst_n,
    input  logic                 rx,
    input  loader_pkg::ahb_rsp_t rsp,
    output loader_pkg::ahb_req_t req,
    output logic                 busy
);
    import loader_pkg::*;

    localparam int IDLE_W = $clog2(`LDR_IDLE_CYCLES);

    typedef enum logic [1:0] {LD_IDLE, LD_ADDR, LD_DATA} ld_state_t;

    ld_state_t         state;
    logic [1:0]        rx_sync;
    logic              byte_valid;
    logic [7:0]        byte_data;
    logic [2:0]        byte_cnt;
    logic [31:0]       addr_q;
    logic [31:0]       data_q;
    logic [IDLE_W-1:0] idle_cnt;
    logic              activity;
    logic              last_byte;
    logic              pending;

    uart_rx rx_inst (
        .hclk       ( hclk       ),
        .rst_n      ( rst_n      ),
        .rx         ( rx         ),
        .byte_valid ( byte_valid ),
        .byte_data  ( byte_data  )
    );

    assign activity  = !rx_sync[1];  // Line low, start or data bit
    assign last_byte = byte_valid && byte_cnt == 3'd7;
    assign pending   = state != LD_IDLE || last_byte;

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n)
            rx_sync <= 2'b11;
        else
            rx_sync <= {rx_sync[0], rx};
    end

    always_ff @(posedge hclk) begin
        if (byte_valid) begin
            if (!byte_cnt[2])
                addr_q <= {addr_q[23:0], byte_data};  // MSB first
            else
                data_q <= {data_q[23:0], byte_data};
        end
    end

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            idle_cnt <= '0;
            byte_cnt <= '0;
        end else if (activity || byte_valid) begin
            busy     <= 1'b1;
            idle_cnt <= '0;
            if (byte_valid)
                byte_cnt <= byte_cnt + 3'd1;
        end else if (busy) begin
            if (idle_cnt != IDLE_W'(`LDR_IDLE_CYCLES - 1)) begin
                idle_cnt <= idle_cnt + IDLE_W'(1);
            end else if (!pending) begin
                busy     <= 1'b0;
                byte_cnt <= '0;  // Resync on a partial record
            end
        end
    end

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: if (last_byte) state <= rsp.hready ? LD_DATA : LD_ADDR;
                LD_ADDR: if (rsp.hready) state <= LD_DATA;
                LD_DATA: if (rsp.hready) state <= LD_IDLE;
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_comb begin
        req.haddr  = addr_q;
        req.htrans = (state == LD_ADDR || (state == LD_IDLE && last_byte)) ? NONSEQ : IDLE;
        req.hwrite = 1'b1;
        req.hwdata = data_q;  // Last byte lands before the data phase
    end
endmodule

// File: hdl/ahb_ram.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module ahb_ram (
    input  logic                 hclk,
    input  logic                 rst_n,
    input  logic                 sel,
    input  loader_pkg::ahb_req_t req,
    output loader_pkg::ahb_rsp_t rsp
);
    import loader_pkg::*;

    localparam int AW = `RAM_ADDR_BITS;

    logic [31:0]   mem [2**AW];
    logic          accept;
    logic [AW-1:0] addr;
    logic [AW-1:0] wr_addr;
    logic          wr_pend;
    logic [31:0]   rd_data;

    assign accept = sel && req.htrans == NONSEQ;
    assign addr   = req.haddr[AW+1:2];  // Word index

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n)
            wr_pend <= 1'b0;
        else
            wr_pend <= accept && req.hwrite;
    end

    always_ff @(posedge hclk) begin
        if (accept)
            wr_addr <= addr;
        if (wr_pend)
            mem[wr_addr] <= req.hwdata;
        if (accept && !req.hwrite)
            rd_data <= (wr_pend && wr_addr == addr) ? req.hwdata : mem[addr];  // Forward
    end

    assign rsp.hrdata = rd_data;
    assign rsp.hready = 1'b1;
    assign rsp.hresp  = 1'b0;
endmodule

// File: hdl/ahb_gpio.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module ahb_gpio (
    input  logic                    hclk,
    input  logic                    rst_n,
    input  logic                    sel,
    input  loader_pkg::ahb_req_t    req,
    input  logic [`N_SWITCHES-1:0]  switches,
    output loader_pkg::ahb_rsp_t    rsp,
    output logic [`N_LEDS-1:0]      leds
);
    import loader_pkg::*;

    logic                   accept;
    logic                   wr_led;
    logic [`N_LEDS-1:0]     led_next;
    logic [`N_SWITCHES-1:0] sw_meta;
    logic [`N_SWITCHES-1:0] sw_s;
    logic [31:0]            rd_data;

    assign accept   = sel && req.htrans == NONSEQ;
    assign led_next = wr_led ? req.hwdata[`N_LEDS-1:0] : leds;  // Pending write wins

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_led <= 1'b0;
            leds   <= '0;
        end else begin
            wr_led <= accept && req.hwrite && !req.haddr[2];  // Offset 4 is read only
            leds   <= led_next;
        end
    end

    always_ff @(posedge hclk) begin
        sw_meta <= switches;
        sw_s    <= sw_meta;
        if (accept && !req.hwrite)
            rd_data <= req.haddr[2] ? 32'(sw_s) : 32'(led_next);
    end

    assign rsp.hrdata = rd_data;
    assign rsp.hready = 1'b1;
    assign rsp.hresp  = 1'b0;
endmodule

// File: hdl/ahb_matrix.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module ahb_matrix (
    input  logic                    hclk,
    input  logic                    rst_n,
    input  loader_pkg::ahb_req_t    req,
    input  logic [`N_SWITCHES-1:0]  switches,
    output loader_pkg::ahb_rsp_t    rsp,
    output logic [`N_LEDS-1:0]      leds
);
    import loader_pkg::*;

    localparam logic [31:0] RAM_BASE_A  = `RAM_BASE;
    localparam logic [31:0] GPIO_BASE_A = `GPIO_BASE;
    localparam int          RAM_LSB     = `RAM_ADDR_BITS + 2;
    localparam int          GPIO_LSB    = 3;  // Two registers

    ahb_rsp_t ram_rsp;
    ahb_rsp_t gpio_rsp;
    logic     hit_ram;
    logic     hit_gpio;
    logic     addr_valid;
    logic     dsel_ram;
    logic     dsel_gpio;
    logic     dsel_err;
    logic     err_second;

    assign hit_ram    = req.haddr[31:RAM_LSB] == RAM_BASE_A[31:RAM_LSB];
    assign hit_gpio   = req.haddr[31:GPIO_LSB] == GPIO_BASE_A[31:GPIO_LSB];
    assign addr_valid = req.htrans == NONSEQ && rsp.hready;

    ahb_ram ram (
        .hclk  ( hclk                  ),
        .rst_n ( rst_n                 ),
        .sel   ( hit_ram && rsp.hready ),
        .req   ( req                   ),
        .rsp   ( ram_rsp               )
    );

    ahb_gpio gpio (
        .hclk     ( hclk                   ),
        .rst_n    ( rst_n                  ),
        .sel      ( hit_gpio && rsp.hready ),
        .req      ( req                    ),
        .switches ( switches               ),
        .rsp      ( gpio_rsp               ),
        .leds     ( leds                   )
    );

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            dsel_ram   <= 1'b0;
            dsel_gpio  <= 1'b0;
            dsel_err   <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_second <= dsel_err && !err_second;
            if (rsp.hready) begin
                dsel_ram  <= addr_valid && hit_ram;
                dsel_gpio <= addr_valid && hit_gpio;
                dsel_err  <= addr_valid && !hit_ram && !hit_gpio;
            end
        end
    end

    always_comb begin
        if (dsel_ram)
            rsp = ram_rsp;
        else if (dsel_gpio)
            rsp = gpio_rsp;
        else if (dsel_err)
            rsp = '{hrdata: 32'h0, hready: err_second, hresp: 1'b1};  // Two-cycle error
        else
            rsp = '{hrdata: 32'h0, hready: 1'b1, hresp: 1'b0};
    end
endmodule

// File: hdl/matrix_with_loader.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module matrix_with_loader (
    input  logic                    hclk,
    input  logic                    rst_n,
    input  loader_pkg::ahb_req_t    cpu_req,
    output loader_pkg::ahb_rsp_t    cpu_rsp,
    input  logic                    uart_rx,
    input  logic [`N_SWITCHES-1:0]  switches,
    output logic [`N_LEDS-1:0]      leds,
    output logic                    mfp_reset
);
    import loader_pkg::*;

    ahb_req_t ldr_req;

    uart_loader loader (
        .hclk  ( hclk      ),
        .rst_n ( rst_n     ),
        .rx    ( uart_rx   ),
        .rsp   ( cpu_rsp   ),
        .req   ( ldr_req   ),
        .busy  ( mfp_reset )  // CPU held in reset while loading
    );

    ahb_matrix matrix (
        .hclk     ( hclk                            ),
        .rst_n    ( rst_n                           ),
        .req      ( mfp_reset ? ldr_req : cpu_req   ),
        .switches ( switches                        ),
        .rsp      ( cpu_rsp                         ),
        .leds     ( leds                            )
    );
endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic hclk
);
    initial hclk = 1'b0;

    always #(PERIOD / 2) hclk = ~hclk;
endmodule

// File: dv/matrix_properties.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module matrix_properties (
    input logic                 hclk,
    input logic                 rst_n,
    input loader_pkg::ahb_req_t cpu_req,
    input loader_pkg::ahb_req_t ldr_req,
    input loader_pkg::ahb_rsp_t cpu_rsp,
    input logic                 mfp_reset
);
    import loader_pkg::*;

    localparam logic [31:0] RAM_BASE_A  = `RAM_BASE;
    localparam logic [31:0] GPIO_BASE_A = `GPIO_BASE;
    localparam int          RAM_LSB     = `RAM_ADDR_BITS + 2;

    ahb_req_t bus_req;
    logic     accept;
    logic     hit_slave;
    logic     slave_phase;

    assign bus_req   = mfp_reset ? ldr_req : cpu_req;
    assign accept    = bus_req.htrans == NONSEQ && cpu_rsp.hready;
    assign hit_slave = bus_req.haddr[31:RAM_LSB] == RAM_BASE_A[31:RAM_LSB]
                    || bus_req.haddr[31:3] == GPIO_BASE_A[31:3];

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n)
            slave_phase <= 1'b0;
        else if (cpu_rsp.hready)
            slave_phase <= accept && hit_slave;  // Data phase owned by RAM or GPIO
    end

    error_second_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
        cpu_rsp.hresp && !cpu_rsp.hready |=> cpu_rsp.hresp && cpu_rsp.hready)
        else $error("Error response did not end with hready high");

    error_first_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
        cpu_rsp.hresp && cpu_rsp.hready |-> $past(cpu_rsp.hresp && !cpu_rsp.hready))
        else $error("Error response skipped its wait cycle");

    loader_quiet: assert property (@(posedge hclk) disable iff (!rst_n)
        !mfp_reset |-> ldr_req.htrans == IDLE)
        else $error("Loader drove a transfer while not busy");

    slave_ready: assert property (@(posedge hclk) disable iff (!rst_n)
        slave_phase |-> cpu_rsp.hready)
        else $error("hready low in a RAM or GPIO data phase");
endmodule

bind matrix_with_loader matrix_properties props (
    .hclk      ( hclk      ),
    .rst_n     ( rst_n     ),
    .cpu_req   ( cpu_req   ),
    .ldr_req   ( ldr_req   ),
    .cpu_rsp   ( cpu_rsp   ),
    .mfp_reset ( mfp_reset )
);

// File: dv/tb_top.sv
`timescale 1ns/1ns
`include "loader_defines.svh"

module tb_top;
    import loader_pkg::*;

    localparam int          SEED         = 53019;
    localparam int          RESET_CYC    = 10;
    localparam int          N_RECORDS    = 6;
    localparam int          N_RANDOM     = 200;
    localparam int          BUS_OPS      = 250;
    localparam int          MAX_WAITS    = 4;
    localparam int          BIT_CYC      = `UART_BAUD_DIV;
    localparam int          LOAD_CYC     = N_RECORDS * 8 * 10 * BIT_CYC;
    localparam int          WATCHDOG_CYC =
        2 * (LOAD_CYC + `LDR_IDLE_CYCLES + BUS_OPS * 4 + RESET_CYC);
    localparam logic [31:0] RAM_BASE_A   = `RAM_BASE;
    localparam logic [31:0] GPIO_BASE_A  = `GPIO_BASE;
    localparam int          RAM_LSB      = `RAM_ADDR_BITS + 2;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        err;
    } xfer_t;

    logic                   hclk;
    logic                   rst_n;
    logic                   serial_rx;
    logic [`N_SWITCHES-1:0] switches;
    logic [`N_LEDS-1:0]     leds;
    logic                   mfp_reset;
    ahb_req_t               cpu_req;
    ahb_rsp_t               cpu_rsp;

    logic [31:0]            ref_mem [int];
    logic [`N_LEDS-1:0]     ref_leds;
    logic [`N_SWITCHES-1:0] ref_switches;
    xfer_t                  rd_q [$];
    int                     checked_reads;

    tb_clock clk_gen (.hclk(hclk));

    matrix_with_loader DUT (
        .hclk      ( hclk      ),
        .rst_n     ( rst_n     ),
        .cpu_req   ( cpu_req   ),
        .cpu_rsp   ( cpu_rsp   ),
        .uart_rx   ( serial_rx ),
        .switches  ( switches  ),
        .leds      ( leds      ),
        .mfp_reset ( mfp_reset )
    );

    function automatic logic in_ram(input logic [31:0] addr);
        return addr[31:RAM_LSB] == RAM_BASE_A[31:RAM_LSB];
    endfunction

    function automatic logic in_gpio(input logic [31:0] addr);
        return addr[31:3] == GPIO_BASE_A[31:3];
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[RAM_LSB-1:2]);
    endfunction

    // Reference model of a read
    function automatic xfer_t expected_read(input logic [31:0] addr);
        xfer_t want;
        want.addr = addr;
        want.data = 32'h0;
        want.err  = !(in_ram(addr) || in_gpio(addr));
        if (in_ram(addr) && ref_mem.exists(word_index(addr)))
            want.data = ref_mem[word_index(addr)];
        else if (in_gpio(addr))
            want.data = addr[2] ? 32'(ref_switches) : 32'(ref_leds);
        return want;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
        if (in_ram(addr))
            ref_mem[word_index(addr)] = data;
        else if (in_gpio(addr) && !addr[2])
            ref_leds = data[`N_LEDS-1:0];  // Switch offset is read only
    endfunction

    function automatic string mismatch_line(input string sig, input logic [31:0] got,
                                            input logic [31:0] want);
        return $sformatf("ERROR: %s got 0x%08h expected 0x%08h", sig, got, want);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // Single transfer entered and left on a falling edge
    task automatic bus_transfer(input logic [31:0] addr, input logic wr,
                                input logic [31:0] wdata, output xfer_t res, output int waits);
        assert (cpu_rsp.hready) else abort_run("Bus not ready at the start of a transfer");
        cpu_req.haddr  = addr;
        cpu_req.htrans = NONSEQ;
        cpu_req.hwrite = wr;
        @(negedge hclk);
        cpu_req.htrans = IDLE;
        cpu_req.hwdata = wdata;
        waits = 0;
        while (!cpu_rsp.hready) begin
            waits++;
            assert (waits <= MAX_WAITS) else abort_run("hready stuck low in a data phase");
            @(negedge hclk);
        end
        res.addr = addr;
        res.data = cpu_rsp.hrdata;
        res.err  = cpu_rsp.hresp;
        if (!wr)
            rd_q.push_back(res);
        else if (!res.err)
            model_write(addr, wdata);
        @(negedge hclk);  // Data phase ends on this cycle's rising edge
    endtask

    task automatic cpu_read(input logic [31:0] addr);
        xfer_t res;
        int    waits;
        bus_transfer(addr, 1'b0, 32'h0, res, waits);
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
        xfer_t res;
        xfer_t want;
        int    waits;
        want = expected_read(addr);
        bus_transfer(addr, 1'b1, data, res, waits);
        assert (res.err == want.err)
            else abort_run(mismatch_line("cpu_rsp.hresp", 32'(res.err), 32'(want.err)));
    endtask

    // Read address phase overlaps the write data phase
    task automatic write_then_read(input logic [31:0] addr, input logic [31:0] data);
        xfer_t res;
        assert (cpu_rsp.hready) else abort_run("Bus not ready at the start of a transfer");
        cpu_req.haddr  = addr;
        cpu_req.htrans = NONSEQ;
        cpu_req.hwrite = 1'b1;
        @(negedge hclk);
        assert (cpu_rsp.hready) else abort_run("RAM inserted a wait state on a write");
        cpu_req.hwdata = data;
        cpu_req.hwrite = 1'b0;
        model_write(addr, data);
        @(negedge hclk);
        cpu_req.htrans = IDLE;
        assert (cpu_rsp.hready) else abort_run("RAM inserted a wait state on a read");
        res.addr = addr;
        res.data = cpu_rsp.hrdata;
        res.err  = cpu_rsp.hresp;
        rd_q.push_back(res);
        @(negedge hclk);
    endtask

    task automatic set_switches(input logic [`N_SWITCHES-1:0] value);
        switches     = value;
        ref_switches = value;
        repeat (3) @(negedge hclk);  // Two-flop synchronizer plus margin
    endtask

    task automatic uart_send_byte(input logic [7:0] b);
        serial_rx = 1'b0;
        repeat (BIT_CYC) @(negedge hclk);
        for (int i = 0; i < 8; i++) begin
            serial_rx = b[i];
            repeat (BIT_CYC) @(negedge hclk);
        end
        serial_rx = 1'b1;
        repeat (BIT_CYC) @(negedge hclk);
    endtask

    task automatic send_record(input logic [31:0] addr, input logic [31:0] data);
        logic [63:0] rec;
        rec = {addr, data};
        for (int i = 7; i >= 0; i--)
            uart_send_byte(rec[i*8 +: 8]);  // MSB first
    endtask

    initial begin : compare
        xfer_t got;
        xfer_t want;
        forever begin
            @(negedge hclk);
            #1;
            while (rd_q.size() > 0) begin
                got  = rd_q.pop_front();
                want = expected_read(got.addr);
                assert (got.err == want.err)
                    else abort_run(mismatch_line($sformatf("cpu_rsp.hresp @0x%08h", got.addr),
                                                 32'(got.err), 32'(want.err)));
                assert (want.err || got.data == want.data)
                    else abort_run(mismatch_line($sformatf("cpu_rsp.hrdata @0x%08h", got.addr),
                                                 got.data, want.data));
                checked_reads++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge hclk);
        abort_run($sformatf("Timeout, the run did not finish in %0d cycles", WATCHDOG_CYC));
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] rec_addr [N_RECORDS];
        xfer_t       res;
        int          waits;
        int          idle_wait;

        void'($urandom(SEED));
        rst_n         = 1'b0;
        serial_rx     = 1'b1;
        switches      = '0;
        cpu_req       = '{haddr: 32'h0, htrans: IDLE, hwrite: 1'b0, hwdata: 32'h0};
        ref_leds      = '0;
        ref_switches  = '0;
        checked_reads = 0;
        repeat (RESET_CYC) @(negedge hclk);
        rst_n = 1'b1;
        @(negedge hclk);

        // Reset state then plain RAM traffic
        assert (!mfp_reset) else abort_run(mismatch_line("mfp_reset", 32'(mfp_reset), 32'h0));
        assert (leds == '0) else abort_run(mismatch_line("leds", 32'(leds), 32'h0));
        for (int i = 0; i < 8; i++)
            cpu_write(RAM_BASE_A + 32'(i * 4), $urandom());
        for (int i = 0; i < 8; i++)
            cpu_read(RAM_BASE_A + 32'(i * 4));
        write_then_read(RAM_BASE_A + 32'h10, 32'hCAFE_0010);
        write_then_read(RAM_BASE_A + 32'h3FC, $urandom());

        // Serial load
        for (int r = 0; r < N_RECORDS; r++) begin
            rec_addr[r] = RAM_BASE_A + 32'($urandom_range(64, 255) * 4);
            addr        = $urandom();
            send_record(rec_addr[r], addr);
            model_write(rec_addr[r], addr);
            assert (mfp_reset) else abort_run("mfp_reset is low while records are loading");
        end
        idle_wait = 0;
        while (mfp_reset) begin
            @(negedge hclk);
            idle_wait++;
            assert (idle_wait < `LDR_IDLE_CYCLES + 4 * BIT_CYC)
                else abort_run("mfp_reset did not fall after the loader idle timeout");
        end
        assert (idle_wait >= `LDR_IDLE_CYCLES - BIT_CYC)
            else abort_run(mismatch_line("mfp_reset idle cycles", idle_wait, `LDR_IDLE_CYCLES));
        for (int r = 0; r < N_RECORDS; r++)
            cpu_read(rec_addr[r]);

        // GPIO
        cpu_write(GPIO_BASE_A, 32'hA5A5_1234);
        assert (leds == ref_leds) else abort_run(mismatch_line("leds", 32'(leds), 32'(ref_leds)));
        cpu_read(GPIO_BASE_A);
        set_switches(`N_SWITCHES'($urandom()));
        cpu_read(GPIO_BASE_A + 32'h4);
        cpu_write(GPIO_BASE_A + 32'h4, 32'hFFFF_FFFF);
        assert (leds == ref_leds) else abort_run(mismatch_line("leds", 32'(leds), 32'(ref_leds)));
        cpu_read(GPIO_BASE_A + 32'h4);
        cpu_read(GPIO_BASE_A);

        // Unmapped address then a legal access
        bus_transfer(32'h4000_0000, 1'b0, 32'h0, res, waits);
        assert (waits == 1)
            else abort_run(mismatch_line("cpu_rsp.hready low cycles", waits, 32'h1));
        cpu_write(32'h4000_0100, 32'h1234_5678);
        cpu_read(RAM_BASE_A + 32'h10);

        // Random mix over RAM and GPIO
        for (int i = 0; i < N_RANDOM; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                addr = GPIO_BASE_A + 32'($urandom_range(0, 1) * 4);
                if ($urandom_range(0, 1) == 1)
                    cpu_write(addr, $urandom());
                else
                    cpu_read(addr);
            end else begin
                addr = RAM_BASE_A + 32'($urandom_range(0, 63) * 4);
                if (ref_mem.exists(word_index(addr)) && $urandom_range(0, 1) == 1)
                    cpu_read(addr);
                else
                    cpu_write(addr, $urandom());
            end
        end

        if (rd_q.size() == 0 && checked_reads > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("Read results were left unchecked");
        end
    end
endmodule

// File: all.f
+incdir+hdl
hdl/loader_pkg.sv
hdl/uart_rx.sv
hdl/uart_loader.sv
hdl/ahb_ram.sv
hdl/ahb_gpio.sv
hdl/ahb_matrix.sv
hdl/matrix_with_loader.sv
dv/tb_clock.sv
dv/matrix_properties.sv
dv/tb_top.sv
